/* Makefile */
VERILATOR ?= verilator
TOP       ?= kiwi_core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/kiwi_core_chk.sv */
`timescale 1ns/1ns

module kiwi_core_chk
    import kiwi_pkg::*;
(
    input logic     clk,
    input logic     rst_n_i,
    input logic     wb_valid_i,
    input reg_idx_t wb_rd_i,
    input logic     redirect_i
);

    // one pulse per taken branch or jump
    redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_i |=> !redirect_i)
        else $error("redirect_o stayed high for two cycles");

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_i |-> wb_rd_i != '0)
        else $error("writeback reported for x0");

    // synchronous reset, so outputs clear one edge later
    reset_quiet: assert property (@(posedge clk) !rst_n_i |=> !wb_valid_i && !redirect_i)
        else $error("writeback or redirect active during reset");

endmodule

bind kiwi_core kiwi_core_chk u_chk (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wb_valid_i (wb_valid_o),
    .wb_rd_i    (wb_rd_o),
    .redirect_i (redirect_o)
);

/* bench/kiwi_core_tb.sv */
`timescale 1ns/1ns

module kiwi_core_tb
    import kiwi_pkg::*;
();

    localparam int XLEN        = 64;
    localparam int DRIVE_DELAY = 2;
    localparam int WAIT_LIMIT  = 20;

    logic            clk;
    logic            rst_n_i;
    logic            inst_valid_i;
    logic [XLEN-1:0] inst_pc_i;
    inst_t           inst_i;
    logic            wb_valid_o;
    reg_idx_t        wb_rd_o;
    logic [XLEN-1:0] wb_value_o;
    logic            redirect_o;
    logic [XLEN-1:0] redirect_pc_o;

    // stimulus and expectation table
    bit              row_valid [$];
    logic [XLEN-1:0] row_pc [$];
    inst_t           row_inst [$];
    bit              exp_wb [$];
    reg_idx_t        exp_rd [$];
    logic [XLEN-1:0] exp_value [$];
    bit              exp_redir [$];
    logic [XLEN-1:0] exp_target [$];

    int cycle_count = 0;
    int error_count = 0;
    int checked     = 0;
    bit timed_out   = 0;

    kiwi_core #(
        .XLEN(XLEN)
    ) UUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_pc_i     (inst_pc_i),
        .inst_i        (inst_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_value_o    (wb_value_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // instruction assemblers in RISC-V field order
    function automatic inst_t r_type(input int f7, input int rs2, input int rs1,
                                     input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic inst_t i_type(input int imm, input int rs1, input int f3,
                                     input int rd, input opc_t opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic inst_t u_type(input int imm, input int rd, input opc_t opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic inst_t b_type(input int imm, input int rs2, input int rs1, input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic inst_t j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic add_row(input int v, input int pc, input inst_t inst, input int wv,
                           input int rd, input logic [XLEN-1:0] value, input int rv,
                           input int rpc);
        row_valid.push_back(v != 0);
        row_pc.push_back(64'(pc));
        row_inst.push_back(inst);
        exp_wb.push_back(wv != 0);
        exp_rd.push_back(rd[4:0]);
        exp_value.push_back(value);
        exp_redir.push_back(rv != 0);
        exp_target.push_back(64'(rpc));
    endtask

    task automatic build_table();
        // idle after reset
        add_row(0, 'h0, 32'h0, 0, 0, 64'h0, 0, 0);
        add_row(0, 'h0, 32'h0, 0, 0, 64'h0, 0, 0);
        add_row(0, 'h0, 32'h0, 0, 0, 64'h0, 0, 0);
        // alu ops with operand distances 1 to 3
        add_row(1, 'h1000, i_type(5, 0, 0, 1, OPC_OP_IMM), 1, 1, 64'h5, 0, 0);
        add_row(1, 'h1004, i_type(-3, 0, 0, 2, OPC_OP_IMM), 1, 2, 64'hffff_ffff_ffff_fffd, 0, 0);
        add_row(1, 'h1008, r_type('h00, 2, 1, 0, 3), 1, 3, 64'h2, 0, 0);
        add_row(1, 'h100c, r_type('h20, 2, 1, 0, 4), 1, 4, 64'h8, 0, 0);
        add_row(1, 'h1010, r_type('h00, 4, 3, 7, 5), 1, 5, 64'h0, 0, 0);
        add_row(1, 'h1014, r_type('h00, 4, 3, 6, 6), 1, 6, 64'ha, 0, 0);
        add_row(1, 'h1018, r_type('h00, 1, 2, 4, 7), 1, 7, 64'hffff_ffff_ffff_fff8, 0, 0);
        add_row(1, 'h101c, r_type('h00, 1, 2, 2, 8), 1, 8, 64'h1, 0, 0);
        add_row(1, 'h1020, r_type('h00, 1, 2, 3, 9), 1, 9, 64'h0, 0, 0);
        add_row(1, 'h1024, i_type(4, 1, 1, 10, OPC_OP_IMM), 1, 10, 64'h50, 0, 0);
        add_row(1, 'h1028, i_type(60, 2, 5, 11, OPC_OP_IMM), 1, 11, 64'hf, 0, 0);
        add_row(1, 'h102c, i_type('h401, 2, 5, 12, OPC_OP_IMM), 1, 12, 64'hffff_ffff_ffff_fffe, 0, 0);
        add_row(1, 'h1030, r_type('h20, 1, 2, 5, 13), 1, 13, 64'hffff_ffff_ffff_ffff, 0, 0);
        add_row(1, 'h1034, i_type(2, 13, 0, 14, OPC_OP_IMM), 1, 14, 64'h1, 0, 0);
        // upper immediates and x0
        add_row(1, 'h1038, u_type('h12345, 15, OPC_LUI), 1, 15, 64'h1234_5000, 0, 0);
        add_row(1, 'h103c, u_type('h80000, 16, OPC_LUI), 1, 16, 64'hffff_ffff_8000_0000, 0, 0);
        add_row(1, 'h1040, u_type('h1, 17, OPC_AUIPC), 1, 17, 64'h2040, 0, 0);
        add_row(1, 'h1044, i_type(7, 1, 0, 0, OPC_OP_IMM), 0, 0, 64'h0, 0, 0);
        add_row(1, 'h1048, r_type('h00, 1, 0, 0, 18), 1, 18, 64'h5, 0, 0);
        // beq and bltu taken, bne not taken
        add_row(1, 'h104c, b_type(16, 18, 1, 0), 0, 0, 64'h0, 1, 'h105c);
        add_row(1, 'h1050, i_type(99, 0, 0, 19, OPC_OP_IMM), 0, 0, 64'h0, 0, 0);
        add_row(1, 'h105c, b_type(8, 2, 1, 6), 0, 0, 64'h0, 1, 'h1064);
        add_row(1, 'h1060, i_type(77, 0, 0, 19, OPC_OP_IMM), 0, 0, 64'h0, 0, 0);
        add_row(1, 'h1064, b_type(32, 18, 1, 1), 0, 0, 64'h0, 0, 0);
        add_row(1, 'h1068, i_type(33, 0, 0, 20, OPC_OP_IMM), 1, 20, 64'h21, 0, 0);
        // jal shadowed by another jal, then jalr with an odd sum
        add_row(1, 'h106c, j_type('h20, 21), 1, 21, 64'h1070, 1, 'h108c);
        add_row(1, 'h1070, j_type('h10, 22), 0, 0, 64'h0, 0, 0);
        add_row(1, 'h108c, i_type(3, 10, 0, 23, OPC_JALR), 1, 23, 64'h1090, 1, 'h52);
        add_row(1, 'h1090, i_type(2, 0, 0, 24, OPC_OP_IMM), 0, 0, 64'h0, 0, 0);
        add_row(1, 'h52, r_type('h00, 21, 23, 0, 25), 1, 25, 64'h2100, 0, 0);
        // x19 must still be zero after both squashes
        add_row(1, 'h56, i_type(0, 19, 0, 26, OPC_OP_IMM), 1, 26, 64'h0, 0, 0);
    endtask

    task automatic wait_for_cycle(input int target);
        int guard;
        guard = 0;
        while (cycle_count < target && guard < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            guard++;
        end
        if (cycle_count < target) begin
            $display("timeout while waiting for clock cycle %0d", target);
            timed_out = 1;
        end
    endtask

    task automatic drive_row(input int r);
        inst_valid_i = row_valid[r];
        inst_pc_i    = row_pc[r];
        inst_i       = row_inst[r];
    endtask

    task automatic check_row(input int r);
        bit ok;
        ok = 1;
        assert (wb_valid_o === exp_wb[r]) else begin
            $display("ERROR row %0d: wb_valid_o is %h, expected %h", r, wb_valid_o, exp_wb[r]);
            ok = 0;
        end
        if (exp_wb[r]) begin
            assert (wb_rd_o === exp_rd[r]) else begin
                $display("ERROR row %0d: wb_rd_o is %h, expected %h", r, wb_rd_o, exp_rd[r]);
                ok = 0;
            end
            assert (wb_value_o === exp_value[r]) else begin
                $display("ERROR row %0d: wb_value_o is %h, expected %h", r, wb_value_o,
                         exp_value[r]);
                ok = 0;
            end
        end
        assert (redirect_o === exp_redir[r]) else begin
            $display("ERROR row %0d: redirect_o is %h, expected %h", r, redirect_o, exp_redir[r]);
            ok = 0;
        end
        if (exp_redir[r]) begin
            assert (redirect_pc_o === exp_target[r]) else begin
                $display("ERROR row %0d: redirect_pc_o is %h, expected %h", r, redirect_pc_o,
                         exp_target[r]);
                ok = 0;
            end
        end
        checked++;
        if (ok) begin
            $display("row %0d pc %h: ok", r, row_pc[r]);
        end else begin
            $display("row %0d pc %h: mismatch", r, row_pc[r]);
            error_count++;
        end
    endtask

    initial begin
        int base;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_pc_i    = '0;
        inst_i       = '0;
        build_table();
        wait_for_cycle(5);
        rst_n_i = 1'b1;
        base = cycle_count;
        // results of row r show up two drive slots later
        for (int i = 0; i < row_valid.size() + 2; i++) begin
            wait_for_cycle(base + i);
            if (timed_out) begin
                break;
            end
            if (i >= 2) begin
                check_row(i - 2);
            end
            if (i < row_valid.size()) begin
                drive_row(i);
            end else begin
                inst_valid_i = 1'b0;
            end
        end
        $display("%0d rows checked, %0d with errors", checked, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* rtl/kiwi_core.sv */
`timescale 1ns/1ns

module kiwi_core
    import kiwi_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            inst_valid_i,
    input  logic [XLEN-1:0] inst_pc_i,
    input  inst_t           inst_i,
    output logic            wb_valid_o,
    output reg_idx_t        wb_rd_o,
    output logic [XLEN-1:0] wb_value_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    reg_idx_t        rf_rs1;
    reg_idx_t        rf_rs2;
    logic [XLEN-1:0] rf_rs1_value;
    logic [XLEN-1:0] rf_rs2_value;

    logic            dec_valid;
    logic [XLEN-1:0] dec_pc;
    logic [XLEN-1:0] dec_op_a;
    logic [XLEN-1:0] dec_op_b;
    logic [XLEN-1:0] dec_imm;
    alu_op_t         dec_alu_op;
    logic [2:0]      dec_cond;
    logic            dec_branch;
    logic            dec_jump;
    logic            dec_wr;
    reg_idx_t        dec_rd;

    logic            exe_valid;
    logic            exe_wr;
    reg_idx_t        exe_rd;
    logic [XLEN-1:0] exe_value;
    logic            exe_taken;
    logic [XLEN-1:0] exe_target;

    kiwi_decode #(
        .XLEN(XLEN)
    ) u_decode (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_pc_i      (inst_pc_i),
        .inst_i         (inst_i),
        .rf_rs1_value_i (rf_rs1_value),
        .rf_rs2_value_i (rf_rs2_value),
        .exe_value_i    (exe_value),
        .exe_taken_i    (exe_taken),
        .rf_rs1_o       (rf_rs1),
        .rf_rs2_o       (rf_rs2),
        .dec_valid_o    (dec_valid),
        .dec_pc_o       (dec_pc),
        .dec_op_a_o     (dec_op_a),
        .dec_op_b_o     (dec_op_b),
        .dec_imm_o      (dec_imm),
        .dec_alu_op_o   (dec_alu_op),
        .dec_cond_o     (dec_cond),
        .dec_branch_o   (dec_branch),
        .dec_jump_o     (dec_jump),
        .dec_wr_o       (dec_wr),
        .dec_rd_o       (dec_rd)
    );

    kiwi_execute #(
        .XLEN(XLEN)
    ) u_execute (
        .dec_valid_i  (dec_valid),
        .dec_pc_i     (dec_pc),
        .dec_op_a_i   (dec_op_a),
        .dec_op_b_i   (dec_op_b),
        .dec_imm_i    (dec_imm),
        .dec_alu_op_i (dec_alu_op),
        .dec_cond_i   (dec_cond),
        .dec_branch_i (dec_branch),
        .dec_jump_i   (dec_jump),
        .dec_wr_i     (dec_wr),
        .dec_rd_i     (dec_rd),
        .exe_valid_o  (exe_valid),
        .exe_wr_o     (exe_wr),
        .exe_rd_o     (exe_rd),
        .exe_value_o  (exe_value),
        .exe_taken_o  (exe_taken),
        .exe_target_o (exe_target)
    );

    kiwi_result #(
        .XLEN(XLEN)
    ) u_result (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .exe_valid_i   (exe_valid),
        .exe_wr_i      (exe_wr),
        .exe_rd_i      (exe_rd),
        .exe_value_i   (exe_value),
        .exe_taken_i   (exe_taken),
        .exe_target_i  (exe_target),
        .rs1_i         (rf_rs1),
        .rs2_i         (rf_rs2),
        .rs1_value_o   (rf_rs1_value),
        .rs2_value_o   (rf_rs2_value),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_value_o    (wb_value_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

/* rtl/kiwi_decode.sv */
`timescale 1ns/1ns

module kiwi_decode
    import kiwi_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            inst_valid_i,
    input  logic [XLEN-1:0] inst_pc_i,
    input  inst_t           inst_i,
    input  logic [XLEN-1:0] rf_rs1_value_i,
    input  logic [XLEN-1:0] rf_rs2_value_i,
    input  logic [XLEN-1:0] exe_value_i,
    input  logic            exe_taken_i,
    output reg_idx_t        rf_rs1_o,
    output reg_idx_t        rf_rs2_o,
    output logic            dec_valid_o,
    output logic [XLEN-1:0] dec_pc_o,
    output logic [XLEN-1:0] dec_op_a_o,
    output logic [XLEN-1:0] dec_op_b_o,
    output logic [XLEN-1:0] dec_imm_o,
    output alu_op_t         dec_alu_op_o,
    output logic [2:0]      dec_cond_o,
    output logic            dec_branch_o,
    output logic            dec_jump_o,
    output logic            dec_wr_o,
    output reg_idx_t        dec_rd_o
);

    opc_t            opc;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [XLEN-1:0] rs1_value;
    logic [XLEN-1:0] rs2_value;
    alu_op_t         alu_fn;
    alu_op_t         alu_op;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            is_branch;
    logic            is_jump;
    logic            wr;

    assign opc      = inst_i[6:0];
    assign funct3   = inst_i[14:12];
    assign rf_rs1_o = inst_i[19:15];
    assign rf_rs2_o = inst_i[24:20];

    assign imm_i = XLEN'($signed(inst_i[31:20]));
    assign imm_u = XLEN'($signed({inst_i[31:12], 12'b0}));
    assign imm_b = XLEN'($signed({inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0}));
    assign imm_j = XLEN'($signed({inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0}));

    // bypass from the instruction now in execute
    assign fwd_rs1   = dec_valid_o && dec_wr_o && (dec_rd_o != '0) && (dec_rd_o == rf_rs1_o);
    assign fwd_rs2   = dec_valid_o && dec_wr_o && (dec_rd_o != '0) && (dec_rd_o == rf_rs2_o);
    assign rs1_value = fwd_rs1 ? exe_value_i : rf_rs1_value_i;
    assign rs2_value = fwd_rs2 ? exe_value_i : rf_rs2_value_i;

    // inst[30] picks sub and sra, but only reg-reg for sub
    always_comb begin
        case (funct3)
            3'b000:  alu_fn = (opc == OPC_OP && inst_i[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_fn = ALU_SLL;
            3'b010:  alu_fn = ALU_SLT;
            3'b011:  alu_fn = ALU_SLTU;
            3'b100:  alu_fn = ALU_XOR;
            3'b101:  alu_fn = inst_i[30] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_fn = ALU_OR;
            default: alu_fn = ALU_AND;
        endcase
    end

    always_comb begin
        alu_op    = ALU_ADD;
        imm       = imm_i;
        op_a      = rs1_value;
        op_b      = imm_i;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        wr        = 1'b0;
        case (opc)
            OPC_OP: begin
                alu_op = alu_fn;
                op_b   = rs2_value;
                wr     = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op = alu_fn;
                wr     = 1'b1;
            end
            OPC_LUI: begin
                imm  = imm_u;
                op_a = '0;
                op_b = imm_u;
                wr   = 1'b1;
            end
            OPC_AUIPC: begin
                imm  = imm_u;
                op_a = inst_pc_i;
                op_b = imm_u;
                wr   = 1'b1;
            end
            OPC_BRANCH: begin
                imm       = imm_b;
                op_b      = rs2_value;
                is_branch = 1'b1;
            end
            // jal carries its pc in op_a so execute forms both targets alike
            OPC_JAL: begin
                imm     = imm_j;
                op_a    = inst_pc_i;
                op_b    = imm_j;
                is_jump = 1'b1;
                wr      = 1'b1;
            end
            OPC_JALR: begin
                is_jump = 1'b1;
                wr      = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // the slot right after a taken branch or jump is dropped
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= inst_valid_i && !exe_taken_i;
        end
    end

    always_ff @(posedge clk) begin
        dec_pc_o     <= inst_pc_i;
        dec_op_a_o   <= op_a;
        dec_op_b_o   <= op_b;
        dec_imm_o    <= imm;
        dec_alu_op_o <= alu_op;
        dec_cond_o   <= funct3;
        dec_branch_o <= is_branch;
        dec_jump_o   <= is_jump;
        dec_wr_o     <= wr;
        dec_rd_o     <= inst_i[11:7];
    end

endmodule

/* rtl/kiwi_execute.sv */
`timescale 1ns/1ns

module kiwi_execute
    import kiwi_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            dec_valid_i,
    input  logic [XLEN-1:0] dec_pc_i,
    input  logic [XLEN-1:0] dec_op_a_i,
    input  logic [XLEN-1:0] dec_op_b_i,
    input  logic [XLEN-1:0] dec_imm_i,
    input  alu_op_t         dec_alu_op_i,
    input  logic [2:0]      dec_cond_i,
    input  logic            dec_branch_i,
    input  logic            dec_jump_i,
    input  logic            dec_wr_i,
    input  reg_idx_t        dec_rd_i,
    output logic            exe_valid_o,
    output logic            exe_wr_o,
    output reg_idx_t        exe_rd_o,
    output logic [XLEN-1:0] exe_value_o,
    output logic            exe_taken_o,
    output logic [XLEN-1:0] exe_target_o
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  shamt;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            cond_ok;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] jump_target;

    assign shamt = dec_op_b_i[SHW-1:0];
    assign eq    = (dec_op_a_i == dec_op_b_i);
    assign lt_s  = ($signed(dec_op_a_i) < $signed(dec_op_b_i));
    assign lt_u  = (dec_op_a_i < dec_op_b_i);

    always_comb begin
        case (dec_alu_op_i)
            ALU_SUB:  alu_res = dec_op_a_i - dec_op_b_i;
            ALU_AND:  alu_res = dec_op_a_i & dec_op_b_i;
            ALU_OR:   alu_res = dec_op_a_i | dec_op_b_i;
            ALU_XOR:  alu_res = dec_op_a_i ^ dec_op_b_i;
            ALU_SLL:  alu_res = dec_op_a_i << shamt;
            ALU_SRL:  alu_res = dec_op_a_i >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(dec_op_a_i) >>> shamt);
            ALU_SLT:  alu_res = XLEN'(lt_s);
            ALU_SLTU: alu_res = XLEN'(lt_u);
            default:  alu_res = dec_op_a_i + dec_op_b_i;
        endcase
    end

    // funct3 of the branch
    always_comb begin
        case (dec_cond_i)
            3'b000:  cond_ok = eq;
            3'b001:  cond_ok = !eq;
            3'b100:  cond_ok = lt_s;
            3'b101:  cond_ok = !lt_s;
            3'b110:  cond_ok = lt_u;
            3'b111:  cond_ok = !lt_u;
            default: cond_ok = 1'b0;
        endcase
    end

    // op_a is the pc for jal, rs1 for jalr
    assign jump_target = dec_op_a_i + dec_imm_i;

    assign exe_valid_o  = dec_valid_i;
    assign exe_wr_o     = dec_wr_i;
    assign exe_rd_o     = dec_rd_i;
    assign exe_value_o  = dec_jump_i ? dec_pc_i + XLEN'(4) : alu_res;
    assign exe_taken_o  = dec_valid_i && (dec_jump_i || (dec_branch_i && cond_ok));
    assign exe_target_o = dec_jump_i ? {jump_target[XLEN-1:1], 1'b0} : dec_pc_i + dec_imm_i;

endmodule

/* rtl/kiwi_pkg.sv */
package kiwi_pkg;

    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [6:0]  opc_t;

    localparam int NUM_REGS = 32;

    // major opcodes of the kept RV64I subset
    localparam opc_t OPC_OP     = 7'b0110011;
    localparam opc_t OPC_OP_IMM = 7'b0010011;
    localparam opc_t OPC_LUI    = 7'b0110111;
    localparam opc_t OPC_AUIPC  = 7'b0010111;
    localparam opc_t OPC_BRANCH = 7'b1100011;
    localparam opc_t OPC_JAL    = 7'b1101111;
    localparam opc_t OPC_JALR   = 7'b1100111;

    // alu operations
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;
    localparam alu_op_t ALU_SLTU = 4'd9;

endpackage

/* rtl/kiwi_result.sv */
`timescale 1ns/1ns

module kiwi_result
    import kiwi_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            exe_valid_i,
    input  logic            exe_wr_i,
    input  reg_idx_t        exe_rd_i,
    input  logic [XLEN-1:0] exe_value_i,
    input  logic            exe_taken_i,
    input  logic [XLEN-1:0] exe_target_i,
    input  reg_idx_t        rs1_i,
    input  reg_idx_t        rs2_i,
    output logic [XLEN-1:0] rs1_value_o,
    output logic [XLEN-1:0] rs2_value_o,
    output logic            wb_valid_o,
    output reg_idx_t        wb_rd_o,
    output logic [XLEN-1:0] wb_value_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            redirect_o <= 1'b0;
        end else begin
            wb_valid_o <= exe_valid_i && exe_wr_i && (exe_rd_i != '0);
            redirect_o <= exe_taken_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o       <= exe_rd_i;
        wb_value_o    <= exe_value_i;
        redirect_pc_o <= exe_target_i;
    end

    // architectural registers come up as zero
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid_o) begin
            regs[wb_rd_o] <= wb_value_o;
        end
    end

    // write-through of the pending writeback
    assign rs1_value_o = (rs1_i == '0) ? '0 :
                         (wb_valid_o && wb_rd_o == rs1_i) ? wb_value_o : regs[rs1_i];
    assign rs2_value_o = (rs2_i == '0) ? '0 :
                         (wb_valid_o && wb_rd_o == rs2_i) ? wb_value_o : regs[rs2_i];

endmodule

/* sources.f */
rtl/kiwi_pkg.sv
rtl/kiwi_decode.sv
rtl/kiwi_execute.sv
rtl/kiwi_result.sv
rtl/kiwi_core.sv
bench/kiwi_core_chk.sv
bench/kiwi_core_tb.sv
